//--- hw/nr_rx_pkg.sv
package nr_rx_pkg;

    localparam int SAMPLE_W  = 8;   // Signed I or Q component
    localparam int BIN_W     = 10;  // Room for 4-point sum growth
    localparam int FFT_LEN   = 4;
    localparam int CP_LEN    = 1;
    localparam int PSS_LEN   = 8;
    localparam int SYM_IDX_W = 2;

    // Role of an SSB symbol
    typedef enum logic [1:0] {
        SYM_PSS    = 2'd0,
        SYM_PBCH_A = 2'd1,
        SYM_SSS    = 2'd2,
        SYM_PBCH_B = 2'd3
    } ssb_sym_e;

    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,
        FS_CP   = 2'd1,
        FS_DATA = 2'd2
    } fs_state_e;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } sample_t;

    typedef struct packed {
        logic signed [BIN_W-1:0] re;
        logic signed [BIN_W-1:0] im;
    } bin_t;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

    typedef struct packed {
        logic     valid;
        sample_t  data;
        logic     last;     // 4th sample of a symbol
        ssb_sym_e kind;
    } sym_beat_t;

    typedef struct packed {
        logic                 valid;
        bin_t                 data;
        logic [SYM_IDX_W-1:0] idx;  // Bin number
        ssb_sym_e             kind;
    } bin_beat_t;

endpackage

//--- hw/pss_detector.sv
`timescale 1ns/1ps

module pss_detector #(
    parameter logic [nr_rx_pkg::PSS_LEN-1:0] PSS_TAPS = 8'b1_1110010,
    parameter int DETECT_THRESHOLD = 64,
    parameter int HOLDOFF_LEN      = 24
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  nr_rx_pkg::sample_beat_t s_beat_i,
    output nr_rx_pkg::sample_beat_t m_beat_o,
    output logic                    peak_o
);
    import nr_rx_pkg::*;

    localparam int ACC_W    = SAMPLE_W + $clog2(PSS_LEN) + 1;
    localparam int METRIC_W = ACC_W + 1;
    localparam int HOLD_W   = $clog2(HOLDOFF_LEN + 1);
    localparam int FILL_W   = $clog2(PSS_LEN + 1);
    localparam logic [METRIC_W-1:0] THRESH  = METRIC_W'(DETECT_THRESHOLD);
    localparam logic [HOLD_W-1:0]   HOLD_LD = HOLD_W'(HOLDOFF_LEN);
    localparam logic [FILL_W-1:0]   FULL    = FILL_W'(PSS_LEN);

    // win_q[0] is the newest sample, win_q[PSS_LEN-1] the oldest
    sample_t                 win_q [PSS_LEN];
    logic                    valid_q;
    logic [FILL_W-1:0]       fill_q;
    logic [HOLD_W-1:0]       hold_q;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;
    logic [ACC_W-1:0]        abs_re;
    logic [ACC_W-1:0]        abs_im;
    logic [METRIC_W-1:0]     metric;

    always_ff @(posedge clk_i) begin
        if (s_beat_i.valid) begin
            win_q[0] <= s_beat_i.data;
            for (int i = 1; i < PSS_LEN; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    // Oldest sample meets the tap MSB
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int i = 0; i < PSS_LEN; i++) begin
            if (PSS_TAPS[i]) begin
                sum_re = sum_re + ACC_W'(win_q[i].re);
                sum_im = sum_im + ACC_W'(win_q[i].im);
            end else begin
                sum_re = sum_re - ACC_W'(win_q[i].re);
                sum_im = sum_im - ACC_W'(win_q[i].im);
            end
        end
        abs_re = sum_re[ACC_W-1] ? ACC_W'(-sum_re) : ACC_W'(sum_re);
        abs_im = sum_im[ACC_W-1] ? ACC_W'(-sum_im) : ACC_W'(sum_im);
        metric = {1'b0, abs_re} + {1'b0, abs_im};
    end

    assign peak_o = valid_q && (fill_q == FULL) && (hold_q == '0) && (metric >= THRESH);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            fill_q  <= '0;
            hold_q  <= '0;
        end else begin
            valid_q <= s_beat_i.valid;
            if (s_beat_i.valid && fill_q != FULL) begin
                fill_q <= fill_q + FILL_W'(1);  // Window not yet primed
            end
            if (peak_o) begin
                hold_q <= HOLD_LD;
            end else if (valid_q && hold_q != '0) begin
                hold_q <= hold_q - HOLD_W'(1);
            end
        end
    end

    assign m_beat_o = '{valid: valid_q, data: win_q[0]};

endmodule

//--- hw/frame_sync.sv
`timescale 1ns/1ps

module frame_sync (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  nr_rx_pkg::sample_beat_t s_beat_i,
    input  logic                    peak_i,
    output nr_rx_pkg::sym_beat_t    m_beat_o
);
    import nr_rx_pkg::*;

    localparam int CNT_W = $clog2(FFT_LEN);
    localparam logic [CNT_W-1:0]     CP_LAST  = CNT_W'(CP_LEN - 1);
    localparam logic [CNT_W-1:0]     SMP_LAST = CNT_W'(FFT_LEN - 1);
    localparam logic [SYM_IDX_W-1:0] SYM_LAST = SYM_IDX_W'(2);  // Three symbols after PSS

    fs_state_e            state_q;
    logic [CNT_W-1:0]     smp_cnt_q;
    logic [SYM_IDX_W-1:0] sym_cnt_q;
    logic                 valid_q;
    sample_t              data_q;
    logic                 last_q;
    ssb_sym_e             kind_q;
    logic                 data_beat;

    assign data_beat = (state_q == FS_DATA) && s_beat_i.valid;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= FS_IDLE;
            smp_cnt_q <= '0;
            sym_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= data_beat;
            case (state_q)
                FS_IDLE: begin
                    if (peak_i) begin
                        state_q   <= FS_CP;
                        smp_cnt_q <= '0;
                        sym_cnt_q <= '0;
                    end
                end
                FS_CP: begin
                    if (s_beat_i.valid) begin
                        if (smp_cnt_q == CP_LAST) begin
                            state_q   <= FS_DATA;
                            smp_cnt_q <= '0;
                        end else begin
                            smp_cnt_q <= smp_cnt_q + CNT_W'(1);
                        end
                    end
                end
                FS_DATA: begin
                    if (s_beat_i.valid) begin
                        if (smp_cnt_q == SMP_LAST) begin
                            smp_cnt_q <= '0;
                            if (sym_cnt_q == SYM_LAST) begin
                                state_q <= FS_IDLE;
                            end else begin
                                sym_cnt_q <= sym_cnt_q + SYM_IDX_W'(1);
                                state_q   <= FS_CP;
                            end
                        end else begin
                            smp_cnt_q <= smp_cnt_q + CNT_W'(1);
                        end
                    end
                end
                default: state_q <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_beat) begin
            data_q <= s_beat_i.data;
            last_q <= (smp_cnt_q == SMP_LAST);
            kind_q <= ssb_sym_e'(sym_cnt_q + SYM_IDX_W'(1));  // PBCH_A, SSS, PBCH_B
        end
    end

    assign m_beat_o = '{valid: valid_q, data: data_q, last: last_q, kind: kind_q};

endmodule

//--- hw/fft4_demod.sv
`timescale 1ns/1ps

module fft4_demod (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  nr_rx_pkg::sym_beat_t s_beat_i,
    output nr_rx_pkg::bin_beat_t m_beat_o
);
    import nr_rx_pkg::*;

    localparam int CNT_W = $clog2(FFT_LEN);
    localparam logic [SYM_IDX_W-1:0] BIN_LAST = SYM_IDX_W'(FFT_LEN - 1);

    sample_t                 cap_q [FFT_LEN];
    sample_t                 out_q [FFT_LEN];
    ssb_sym_e                kind_q;
    logic [CNT_W-1:0]        wr_pos_q;
    logic [SYM_IDX_W-1:0]    bin_cnt_q;
    logic                    busy_q;
    logic signed [BIN_W-1:0] xr [FFT_LEN];
    logic signed [BIN_W-1:0] xi [FFT_LEN];
    bin_t                    bin_d;

    always_ff @(posedge clk_i) begin
        if (s_beat_i.valid) begin
            cap_q[wr_pos_q] <= s_beat_i.data;
        end
        if (s_beat_i.valid && s_beat_i.last) begin
            for (int i = 0; i < FFT_LEN; i++) begin
                out_q[i] <= (CNT_W'(i) == wr_pos_q) ? s_beat_i.data : cap_q[i];
            end
            kind_q <= s_beat_i.kind;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_pos_q  <= '0;
            bin_cnt_q <= '0;
            busy_q    <= 1'b0;
        end else begin
            if (s_beat_i.valid) begin
                wr_pos_q <= s_beat_i.last ? '0 : wr_pos_q + CNT_W'(1);
            end
            if (s_beat_i.valid && s_beat_i.last) begin
                busy_q    <= 1'b1;
                bin_cnt_q <= '0;
            end else if (busy_q) begin
                bin_cnt_q <= bin_cnt_q + SYM_IDX_W'(1);
                if (bin_cnt_q == BIN_LAST) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Twiddles are +-1 and +-j, so only adds and re/im swaps
    always_comb begin
        for (int i = 0; i < FFT_LEN; i++) begin
            xr[i] = BIN_W'(out_q[i].re);
            xi[i] = BIN_W'(out_q[i].im);
        end
        case (bin_cnt_q)
            2'd0: begin
                bin_d.re = xr[0] + xr[1] + xr[2] + xr[3];
                bin_d.im = xi[0] + xi[1] + xi[2] + xi[3];
            end
            2'd1: begin                                     // a - jb - c + jd
                bin_d.re = xr[0] + xi[1] - xr[2] - xi[3];
                bin_d.im = xi[0] - xr[1] - xi[2] + xr[3];
            end
            2'd2: begin
                bin_d.re = xr[0] - xr[1] + xr[2] - xr[3];
                bin_d.im = xi[0] - xi[1] + xi[2] - xi[3];
            end
            default: begin                                  // a + jb - c - jd
                bin_d.re = xr[0] - xi[1] - xr[2] + xi[3];
                bin_d.im = xi[0] + xr[1] - xi[2] - xr[3];
            end
        endcase
    end

    assign m_beat_o = '{valid: busy_q, data: bin_d, idx: bin_cnt_q, kind: kind_q};

endmodule

//--- hw/bwp_extractor.sv
`timescale 1ns/1ps

module bwp_extractor #(
    parameter int BWP_START = 1,
    parameter int BWP_LEN   = 2
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  nr_rx_pkg::bin_beat_t s_beat_i,
    output nr_rx_pkg::bin_t      bin_o,
    output logic                 pbch_valid_o,
    output logic                 sss_valid_o
);
    import nr_rx_pkg::*;

    logic in_range;
    logic keep;
    logic is_pbch;
    logic is_sss;
    bin_t bin_q;

    assign in_range = (int'(s_beat_i.idx) >= BWP_START) &&
                      (int'(s_beat_i.idx) < BWP_START + BWP_LEN);
    assign keep     = s_beat_i.valid && in_range;
    assign is_pbch  = (s_beat_i.kind == SYM_PBCH_A) || (s_beat_i.kind == SYM_PBCH_B);
    assign is_sss   = (s_beat_i.kind == SYM_SSS);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            pbch_valid_o <= keep && is_pbch;
            sss_valid_o  <= keep && is_sss;  // PSS bins never flagged
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep) begin
            bin_q <= s_beat_i.data;
        end
    end

    assign bin_o = bin_q;

endmodule

//--- hw/ssb_receiver_top.sv
`timescale 1ns/1ps

module ssb_receiver_top #(
    parameter logic [nr_rx_pkg::PSS_LEN-1:0] PSS_TAPS = 8'b1_1110010,  // Barker-7 plus lead +1
    parameter int DETECT_THRESHOLD = 64,
    parameter int HOLDOFF_LEN      = 24,
    parameter int BWP_START        = 1,
    parameter int BWP_LEN          = 2
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  nr_rx_pkg::sample_beat_t s_beat_i,
    output nr_rx_pkg::bin_t         bin_o,
    output logic                    pbch_valid_o,
    output logic                    sss_valid_o
);
    import nr_rx_pkg::*;

    sample_beat_t pss_beat;
    logic         peak;
    sym_beat_t    sym_beat;
    bin_beat_t    bin_beat;

    pss_detector #(
        .PSS_TAPS         (PSS_TAPS),
        .DETECT_THRESHOLD (DETECT_THRESHOLD),
        .HOLDOFF_LEN      (HOLDOFF_LEN)
    ) pss_detector_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .s_beat_i (s_beat_i),
        .m_beat_o (pss_beat),
        .peak_o   (peak)
    );

    // Only stage that knows SSB symbol timing
    frame_sync frame_sync_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .s_beat_i (pss_beat),
        .peak_i   (peak),
        .m_beat_o (sym_beat)
    );

    fft4_demod fft4_demod_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .s_beat_i (sym_beat),
        .m_beat_o (bin_beat)
    );

    bwp_extractor #(
        .BWP_START (BWP_START),
        .BWP_LEN   (BWP_LEN)
    ) bwp_extractor_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .s_beat_i     (bin_beat),
        .bin_o        (bin_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

endmodule

//--- tests/tb_ssb_receiver.sv
`timescale 1ns/1ps

module tb_ssb_receiver;
    import nr_rx_pkg::*;

    localparam int HALF_PERIOD = 5;
    localparam logic [PSS_LEN-1:0] PSS_TAPS = 8'b1_1110010;  // Time order is MSB first
    localparam int DETECT_THRESHOLD = 64;
    localparam int HOLDOFF_LEN      = 24;
    localparam int BWP_START        = 1;
    localparam int BWP_LEN          = 2;
    localparam int N_SYMS           = 3;
    localparam int QUIET_CYCLES     = 16;

    typedef struct packed {
        logic [7:0] lead;     // Noise samples before the PSS
        logic [7:0] gain;
        logic [7:0] gap;      // Valid pattern, bit per cycle
        logic       impulse;
    } row_t;

    typedef struct packed {
        logic sss;
        bin_t bin;
    } exp_bin_t;

    localparam int N_ROWS = 6;
    localparam row_t STIM [N_ROWS] = '{
        '{8'd12, 8'd12, 8'hff,        1'b0},
        '{8'd10, 8'd16, 8'hff,        1'b1},
        '{8'd9,  8'd20, 8'b1011_0110, 1'b0},
        '{8'd16, 8'd14, 8'b0101_0101, 1'b0},
        '{8'd8,  8'd18, 8'b1110_1111, 1'b1},
        '{8'd11, 8'd13, 8'b1001_1101, 1'b0}
    };

    logic         clk = 1'b0;
    logic         arst_n;
    sample_beat_t s_beat;
    bin_t         bin;
    logic         pbch_valid;
    logic         sss_valid;

    logic [31:0]  lfsr = 32'hdb18;
    logic [2:0]   gap_pos;
    exp_bin_t     exp_q [$];
    exp_bin_t     want;

    ssb_receiver_top #(
        .PSS_TAPS         (PSS_TAPS),
        .DETECT_THRESHOLD (DETECT_THRESHOLD),
        .HOLDOFF_LEN      (HOLDOFF_LEN),
        .BWP_START        (BWP_START),
        .BWP_LEN          (BWP_LEN)
    ) DUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .s_beat_i     (s_beat),
        .bin_o        (bin),
        .pbch_valid_o (pbch_valid),
        .sss_valid_o  (sss_valid)
    );

    always #HALF_PERIOD clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            v    = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] rand_signed(input int nbits);
        logic [31:0] raw;
        int          val;
        raw = rand_bits(nbits);
        val = int'(raw);
        if (raw[nbits-1]) begin
            val = val - (1 << nbits);  // Two's complement of nbits
        end
        return SAMPLE_W'(val);
    endfunction

    // X[k] = sum x[n] * e^(-j*2*pi*k*n/4)
    function automatic bin_t dft_bin(input sample_t x [FFT_LEN], input int k);
        int   acc_re;
        int   acc_im;
        int   xr;
        int   xi;
        bin_t b;
        acc_re = 0;
        acc_im = 0;
        for (int n = 0; n < FFT_LEN; n++) begin
            xr = int'(x[n].re);
            xi = int'(x[n].im);
            case ((k * n) % 4)
                0: begin
                    acc_re += xr;
                    acc_im += xi;
                end
                1: begin                    // Times -j
                    acc_re += xi;
                    acc_im -= xr;
                end
                2: begin
                    acc_re -= xr;
                    acc_im -= xi;
                end
                default: begin              // Times +j
                    acc_re -= xi;
                    acc_im += xr;
                end
            endcase
        end
        b.re = BIN_W'(acc_re);
        b.im = BIN_W'(acc_im);
        return b;
    endfunction

    // Every gap pattern has a valid slot in 8, so 8 cycles per sample at worst
    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += int'(STIM[r].lead) + PSS_LEN + N_SYMS * (CP_LEN + FFT_LEN);
        end
        return total * 8 + QUIET_CYCLES + 100;
    endfunction

    task automatic check_equal(input string what, input int got, input int exp_val);
        if (got !== exp_val) begin
            $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp_val);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_sample(input sample_t s, input logic [7:0] gap);
        logic slot_valid;
        slot_valid = 1'b0;
        while (!slot_valid) begin
            @(posedge clk);
            slot_valid = gap[gap_pos];
            gap_pos    = gap_pos + 3'd1;
            s_beat.valid <= slot_valid;
            s_beat.data  <= slot_valid ? s : sample_t'(~s);  // Junk on gap cycles
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && (pbch_valid || sss_valid)) begin
            check_equal("flags raised together", int'(pbch_valid) + int'(sss_valid), 1);
            check_equal("expected bin pending", int'(exp_q.size() != 0), 1);
            want = exp_q.pop_front();
            check_equal("sss flag", int'(sss_valid), int'(want.sss));
            check_equal("bin re", int'(bin.re), int'(want.bin.re));
            check_equal("bin im", int'(bin.im), int'(want.bin.im));
        end
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles());
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        sample_t  sym [FFT_LEN];
        sample_t  smp;
        exp_bin_t e;
        int       gain;
        int       drain;
        s_beat  = '0;
        arst_n  = 1'b0;
        gap_pos = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            gap_pos = '0;
            gain    = int'(STIM[r].gain);
            for (int i = 0; i < int'(STIM[r].lead); i++) begin
                smp.re = rand_signed(2);
                smp.im = rand_signed(2);
                drive_sample(smp, STIM[r].gap);
            end
            for (int i = PSS_LEN - 1; i >= 0; i--) begin
                smp.re = PSS_TAPS[i] ? SAMPLE_W'(gain) : SAMPLE_W'(-gain);
                smp.im = '0;
                drive_sample(smp, STIM[r].gap);
            end
            for (int sym_i = 0; sym_i < N_SYMS; sym_i++) begin
                for (int n = 0; n < FFT_LEN; n++) begin
                    if (!STIM[r].impulse || n == 0) begin
                        sym[n].re = rand_signed(6);
                        sym[n].im = rand_signed(6);
                    end else begin
                        sym[n] = '0;
                    end
                end
                for (int k = BWP_START; k < BWP_START + BWP_LEN; k++) begin
                    e.sss = (sym_i == 1);  // Middle symbol is SSS
                    e.bin = dft_bin(sym, k);
                    exp_q.push_back(e);
                end
                drive_sample(sym[FFT_LEN-1], STIM[r].gap);  // CP copies the last sample
                for (int n = 0; n < FFT_LEN; n++) begin
                    drive_sample(sym[n], STIM[r].gap);
                end
            end
        end
        @(posedge clk);
        s_beat <= '0;
        drain = 0;
        while (exp_q.size() != 0 && drain < QUIET_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        check_equal("bins left in reference queue", exp_q.size(), 0);
        repeat (QUIET_CYCLES) @(posedge clk);  // No stray bins afterwards
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- sim.f
hw/nr_rx_pkg.sv
hw/pss_detector.sv
hw/frame_sync.sv
hw/fft4_demod.sv
hw/bwp_extractor.sv
hw/ssb_receiver_top.sv
tests/tb_ssb_receiver.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_ssb_receiver
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_STR  := *** TEST PASSED ***

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_STR)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
